// ==== rtl/regPkg.sv ====
package regPkg;

	// --------------------
	// Register selects
	// --------------------

	// Codes 0..7 follow the Z80 r field, so opcode bits map straight onto this
	typedef enum logic [3:0]
	{
		rB    = 4'd0,
		rC    = 4'd1,
		rD    = 4'd2,
		rE    = 4'd3,
		rH    = 4'd4,
		rL    = 4'd5,
		rHl   = 4'd6,  // The H:L pair as one 16-bit value
		rA    = 4'd7,
		rPc   = 4'd8,
		rX8   = 4'd9,  // Scratch byte used by relative jumps
		rX16  = 4'd10, // Scratch word for address math
		rNull = 4'd11
	} regSelE;

	// Flag register layout
	localparam int flagZ = 7;

	// --------------------
	// External memory bus
	// --------------------

	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  wData;
		logic        we;    // One cycle per write micro-op
	} memBusT;

endpackage

// ==== rtl/uopPkg.sv ====
package uopPkg;
	import regPkg::*;

	localparam int uAddrW = 6;

	typedef enum logic [3:0]
	{
		nop,
		sma,    // Latch the memory address select
		srm,    // Read data into a register
		smw,    // Write a register to memory
		inc16,
		addx16, // X16 plus the sign-extended selected byte
		spc,    // Load PC from a register
		srx8,
		sx8r,   // Operand byte from the bus into X8
		sx16r,
		aluOp,  // LD r,r' and the A-based logic ops
		ldImm   // Immediate byte into the register in opcode bits 5..3
	} uopCmdE;

	typedef enum logic [1:0] {eofNever, eofAlways, eofIfZ, eofIfNotZ} eofPredE;

	typedef struct packed
	{
		logic    incPc;
		eofPredE eof;
		uopCmdE  cmd;
		regSelE  src;
	} uopT;

	// Flow entry points in the microcode ROM
	localparam logic [uAddrW-1:0] flowNop   = 6'd0;
	localparam logic [uAddrW-1:0] flowLdImm = 6'd1;
	localparam logic [uAddrW-1:0] flowLdRr  = 6'd3;
	localparam logic [uAddrW-1:0] flowAlu   = 6'd4;
	localparam logic [uAddrW-1:0] flowLdAHl = 6'd5;
	localparam logic [uAddrW-1:0] flowStHlA = 6'd8;
	localparam logic [uAddrW-1:0] flowIncHl = 6'd11;
	localparam logic [uAddrW-1:0] flowJr    = 6'd12;
	localparam logic [uAddrW-1:0] flowJrZ   = 6'd17;
	localparam logic [uAddrW-1:0] uAddrLast = 6'd21; // Last used ROM word

endpackage

// ==== rtl/ucodeRom.sv ====
module ucodeRom
	import regPkg::*, uopPkg::*;
(
	input  logic [uAddrW-1:0] uAddr,
	output uopT               uop
);

	always_comb
	begin
		case (uAddr)
			flowNop:           uop = '{1'b1, eofAlways, nop, rNull};

			// LD r,n steps over the opcode first so the operand is on the bus
			flowLdImm:         uop = '{1'b1, eofNever, nop, rNull};
			flowLdImm + 6'd1:  uop = '{1'b1, eofAlways, ldImm, rNull};

			flowLdRr:          uop = '{1'b1, eofAlways, aluOp, rNull};
			flowAlu:           uop = '{1'b1, eofAlways, aluOp, rNull};

			// --------------------
			// Indirect accesses through HL
			// --------------------
			flowLdAHl:         uop = '{1'b1, eofNever, sma, rHl};
			flowLdAHl + 6'd1:  uop = '{1'b0, eofNever, srm, rA};
			flowLdAHl + 6'd2:  uop = '{1'b0, eofAlways, sma, rPc};
			flowStHlA:         uop = '{1'b1, eofNever, sma, rHl};
			flowStHlA + 6'd1:  uop = '{1'b0, eofNever, smw, rA};
			flowStHlA + 6'd2:  uop = '{1'b0, eofAlways, sma, rPc};

			flowIncHl:         uop = '{1'b1, eofAlways, inc16, rHl};

			// --------------------
			// Relative jumps
			// --------------------
			flowJr:            uop = '{1'b1, eofNever, nop, rNull};
			flowJr + 6'd1:     uop = '{1'b1, eofNever, sx8r, rNull};
			flowJr + 6'd2:     uop = '{1'b0, eofNever, sx16r, rPc};  // PC is already past e
			flowJr + 6'd3:     uop = '{1'b0, eofNever, addx16, rX8};
			flowJr + 6'd4:     uop = '{1'b0, eofAlways, spc, rX16};
			flowJrZ:           uop = '{1'b1, eofNever, nop, rNull};
			// Not taken ends here with PC on the next instruction
			flowJrZ + 6'd1:    uop = '{1'b1, eofIfNotZ, sx8r, rNull};
			flowJrZ + 6'd2:    uop = '{1'b0, eofNever, sx16r, rPc};
			flowJrZ + 6'd3:    uop = '{1'b0, eofNever, addx16, rX8};
			flowJrZ + 6'd4:    uop = '{1'b0, eofAlways, spc, rX16};

			default:           uop = '{1'b0, eofAlways, nop, rNull};
		endcase
	end

	// The sequencer parks on a flow's last word, so it never runs past the table
	always_comb
	begin
		assert ($isunknown(uAddr) || uAddr <= uAddrLast)
		else $error("micro address %0d outside the ROM table", uAddr);
	end

endmodule

// ==== rtl/opcodeFlowLut.sv ====
module opcodeFlowLut
	import uopPkg::*;
(
	input  logic [7:0]        readData,
	output logic [uAddrW-1:0] flowStart
);

	// First match wins, so the special cases sit above their groups
	always_comb
	begin
		casez (readData)
			8'h18:       flowStart = flowJr;
			8'h28:       flowStart = flowJrZ;
			8'h23:       flowStart = flowIncHl;
			8'h36:       flowStart = flowNop;   // LD (HL),n is not supported
			8'b00???110: flowStart = flowLdImm;
			8'h77:       flowStart = flowStHlA;
			8'h7E:       flowStart = flowLdAHl;
			8'h76:       flowStart = flowNop;   // HALT
			8'b01110???: flowStart = flowNop;
			8'b01???110: flowStart = flowNop;
			8'b01??????: flowStart = flowLdRr;
			8'hA6:       flowStart = flowNop;
			8'hAE:       flowStart = flowNop;
			8'b1010????: flowStart = flowAlu;   // AND r and XOR r
			default:     flowStart = flowNop;
		endcase
	end

endmodule

// ==== rtl/flowSequencer.sv ====
module flowSequencer
	import uopPkg::*;
(
	input  logic              iClock,
	input  logic              rstN,
	input  logic [7:0]        readData,
	input  logic [uAddrW-1:0] flowStart,
	input  uopT               uop,
	input  logic              zFlag,
	input  logic              pcLoad,
	input  logic [15:0]       pcValue,
	output logic [uAddrW-1:0] uAddr,
	output logic [15:0]       pc,
	output logic [7:0]        opcode,
	output logic              flowRun
);

	typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqStateE;

	seqStateE state;
	seqStateE nextState;
	logic     eofHit;

	always_comb
	begin
		case (uop.eof)
			eofNever:  eofHit = 1'b0;
			eofAlways: eofHit = 1'b1;
			eofIfZ:    eofHit = zFlag;
			default:   eofHit = !zFlag;
		endcase
	end

	// --------------------
	// Flow state machine
	// --------------------
	always_comb
	begin
		case (state)
			afterReset: nextState = startFlow;
			startFlow:  nextState = runFlow;
			runFlow:    nextState = eofHit ? endFlow : runFlow;
			default:    nextState = startFlow;
		endcase
	end

	always_ff @(posedge iClock)
	begin
		if (!rstN)
			state <= afterReset;
		else
			state <= nextState;
	end

	assign flowRun = (state == runFlow);

	// The micro PC holds on the last word of a flow
	always_ff @(posedge iClock)
	begin
		if (!rstN)
			uAddr <= flowNop;
		else if (state == startFlow)
			uAddr <= flowStart;
		else if (!eofHit)
			uAddr <= uAddr + 1'b1;
	end

	always_ff @(posedge iClock)
	begin
		if (!rstN)
		begin
			pc <= '0;
			opcode <= '0;
		end
		else
		begin
			if (flowRun && pcLoad)
				pc <= pcValue;  // A jump overrides the increment
			else if (flowRun && uop.incPc)
				pc <= pc + 16'd1;
			if (state == startFlow)
				opcode <= readData;
		end
	end

	uAddrHold: assert property (@(posedge iClock) disable iff (!rstN)
		!(state inside {startFlow, runFlow}) |=> $stable(uAddr))
	else $error("micro PC moved outside startFlow and runFlow");

endmodule

// ==== rtl/regFile.sv ====
module regFile
	import regPkg::*;
(
	input  logic        iClock,
	input  logic        rstN,
	input  logic        flowRun,
	input  regSelE      wrSel,
	input  logic [15:0] wrData,
	input  logic        regWe,
	input  logic        flagWe,
	input  logic [7:0]  flagVal,
	input  logic        x16We,
	input  logic        addrSelWe,
	input  regSelE      addrSel,
	input  regSelE      rdSel,
	input  logic [15:0] pc,
	output logic [15:0] rdData,
	output logic [7:0]  regA,
	output logic [7:0]  x8,
	output logic [15:0] x16,
	output logic [7:0]  flags,
	output logic [15:0] memAddr
);

	logic [7:0] regB;
	logic [7:0] regC;
	logic [7:0] regD;
	logic [7:0] regE;
	logic [7:0] regH;
	logic [7:0] regL;
	regSelE     addrSelQ;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge iClock)
	begin
		if (!rstN)
		begin
			regB <= '0;
			regC <= '0;
			regD <= '0;
			regE <= '0;
			regH <= '0;
			regL <= '0;
			regA <= '0;
			x8 <= '0;
		end
		else if (flowRun && regWe)
		begin
			case (wrSel)
				rB:  regB <= wrData[7:0];
				rC:  regC <= wrData[7:0];
				rD:  regD <= wrData[7:0];
				rE:  regE <= wrData[7:0];
				rH:  regH <= wrData[7:0];
				rL:  regL <= wrData[7:0];
				rHl:
				begin
					regH <= wrData[15:8];
					regL <= wrData[7:0];
				end
				rA:  regA <= wrData[7:0];
				rX8: x8 <= wrData[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge iClock)
	begin
		if (!rstN)
		begin
			x16 <= '0;
			flags <= '0;
			addrSelQ <= rPc;  // Fetch from PC out of reset
		end
		else if (flowRun)
		begin
			if (x16We)
				x16 <= wrData;
			if (flagWe)
				flags <= flagVal;
			if (addrSelWe)
				addrSelQ <= addrSel;
		end
	end

	// --------------------
	// Read side
	// --------------------
	function automatic logic [15:0] selValue(input regSelE sel);
		case (sel)
			rB:      return {8'h00, regB};
			rC:      return {8'h00, regC};
			rD:      return {8'h00, regD};
			rE:      return {8'h00, regE};
			rH:      return {8'h00, regH};
			rL:      return {8'h00, regL};
			rHl:     return {regH, regL};
			rA:      return {8'h00, regA};
			rPc:     return pc;
			rX8:     return {8'h00, x8};
			rX16:    return x16;
			default: return 16'h0000;
		endcase
	endfunction

	assign rdData = selValue(rdSel);
	assign memAddr = selValue(addrSelQ);

	noNullWrite: assert property (@(posedge iClock) disable iff (!rstN)
		regWe |-> wrSel != rNull)
	else $error("register write with a null select");

endmodule

// ==== rtl/uopExecute.sv ====
module uopExecute
	import regPkg::*, uopPkg::*;
(
	input  uopT         uop,
	input  logic [7:0]  opcode,
	input  logic [7:0]  readData,
	input  logic [15:0] rdData,
	input  logic [7:0]  regA,
	input  logic [7:0]  x8,
	input  logic [15:0] x16,
	input  logic [7:0]  flags,
	input  logic        flowRun,
	output regSelE      rdSel,
	output regSelE      wrSel,
	output logic [15:0] wrData,
	output logic        regWe,
	output logic        flagWe,
	output logic [7:0]  flagVal,
	output logic        x16We,
	output logic        addrSelWe,
	output regSelE      addrSel,
	output logic        pcLoad,
	output logic [15:0] pcValue,
	output logic        memWe,
	output logic [7:0]  memWData
);

	logic [7:0]  aluRes;
	logic [15:0] incRes;

	// Kept apart from the decode so the read mux does not loop back into it
	always_comb
	begin
		if (uop.cmd == aluOp)
			rdSel = regSelE'({1'b0, opcode[2:0]});
		else
			rdSel = uop.src;
	end

	// --------------------
	// ALU
	// --------------------
	always_comb
	begin
		if (opcode[3])
			aluRes = regA ^ rdData[7:0];  // XOR r
		else
			aluRes = regA & rdData[7:0];  // AND r
	end

	assign incRes = rdData + 16'd1;

	// --------------------
	// Micro-op decode
	// --------------------
	always_comb
	begin
		wrSel = uop.src;
		wrData = 16'h0000;
		regWe = 1'b0;
		flagWe = 1'b0;
		flagVal = 8'h00;
		x16We = 1'b0;
		addrSelWe = 1'b0;
		addrSel = uop.src;
		pcLoad = 1'b0;
		pcValue = rdData;
		memWe = 1'b0;
		memWData = rdData[7:0];
		case (uop.cmd)
			sma: addrSelWe = 1'b1;
			srm:
			begin
				regWe = 1'b1;
				wrData = {8'h00, readData};
			end
			smw: memWe = flowRun;  // Bus strobe only while a flow runs
			inc16:
			begin
				regWe = 1'b1;
				wrData = incRes;
				flagWe = 1'b1;
				flagVal = flags;
				flagVal[flagZ] = (incRes == 16'h0000);
			end
			addx16:
			begin
				x16We = 1'b1;
				wrData = x16 + {{8{rdData[7]}}, rdData[7:0]};
			end
			spc: pcLoad = 1'b1;
			srx8:
			begin
				regWe = 1'b1;
				wrData = {8'h00, x8};
			end
			sx8r:
			begin
				regWe = 1'b1;
				wrSel = rX8;
				wrData = {8'h00, readData};
			end
			sx16r:
			begin
				x16We = 1'b1;
				wrData = rdData;
			end
			aluOp:
			begin
				regWe = 1'b1;
				if (opcode[7:6] == 2'b01)
				begin
					// LD r,r' copies the source without touching flags
					wrSel = regSelE'({1'b0, opcode[5:3]});
					wrData = rdData;
				end
				else
				begin
					wrSel = rA;
					wrData = {8'h00, aluRes};
					flagWe = 1'b1;
					flagVal[flagZ] = (aluRes == 8'h00);
				end
			end
			ldImm:
			begin
				regWe = 1'b1;
				wrSel = regSelE'({1'b0, opcode[5:3]});
				wrData = {8'h00, readData};
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/cpuCore.sv ====
module cpuCore
	import regPkg::*, uopPkg::*;
(
	input  logic       iClock,
	input  logic       rstN,
	input  logic [7:0] readData,
	output memBusT     bus
);

	logic [uAddrW-1:0] uAddr;
	logic [uAddrW-1:0] flowStart;
	uopT               uop;
	logic [15:0]       pc;
	logic [7:0]        opcode;
	logic              flowRun;
	regSelE            rdSel;
	regSelE            wrSel;
	regSelE            addrSel;
	logic [15:0]       rdData;
	logic [15:0]       wrData;
	logic              regWe;
	logic              flagWe;
	logic [7:0]        flagVal;
	logic              x16We;
	logic              addrSelWe;
	logic              pcLoad;
	logic [15:0]       pcValue;
	logic              memWe;
	logic [7:0]        memWData;
	logic [7:0]        regA;
	logic [7:0]        x8;
	logic [15:0]       x16;
	logic [7:0]        flags;
	logic [15:0]       memAddr;

	flowSequencer iSeq (.iClock, .rstN, .readData, .flowStart, .uop,
		.zFlag(flags[flagZ]), .pcLoad, .pcValue, .uAddr, .pc, .opcode, .flowRun);

	ucodeRom iRom (.uAddr, .uop);

	opcodeFlowLut iLut (.readData, .flowStart);

	regFile iRegs (.iClock, .rstN, .flowRun, .wrSel, .wrData, .regWe, .flagWe, .flagVal,
		.x16We, .addrSelWe, .addrSel, .rdSel, .pc, .rdData, .regA, .x8, .x16, .flags,
		.memAddr);

	uopExecute iExec (.uop, .opcode, .readData, .rdData, .regA, .x8, .x16, .flags, .flowRun,
		.rdSel, .wrSel, .wrData, .regWe, .flagWe, .flagVal, .x16We, .addrSelWe, .addrSel,
		.pcLoad, .pcValue, .memWe, .memWData);

	// Address comes from the latched select, data from the execute stage
	assign bus = '{addr: memAddr, wData: memWData, we: memWe};

endmodule

// ==== bench/clockGen.sv ====
module clockGen
(
	output logic iClock
);

	// Toggles every 2 units for a period of 4
	initial
	begin
		iClock = 1'b0;
		forever
			#2 iClock = ~iClock;
	end

endmodule

// ==== bench/cpuBench.sv ====
module cpuBench
	import regPkg::*;
();

	logic       iClock;
	logic       rstN;
	logic [7:0] readData;
	memBusT     bus;

	logic [7:0]  mem [0:65535];
	logic [15:0] expAddr [$];
	logic [7:0]  expData [$];
	int          expCount = 0;
	int          writeIdx = 0;
	int          progBytes = 0;
	int          timeLimit = 0;
	logic        loadDone = 1'b0;
	int          mismatchCount = 0;
	int          extraCount = 0;
	int          otherErrors = 0;

	clockGen iClk (.iClock);

	cpuCore i_dut (.iClock, .rstN, .readData, .bus);

	// Memory answers in the same cycle as the address
	assign readData = mem[bus.addr];

	function automatic logic [7:0] logicResult(input logic [7:0] a, input logic [7:0] b,
		input logic isXor);
		if (isXor)
			return a ^ b;
		else
			return a & b;
	endfunction

	// --------------------
	// Program file
	// --------------------
	task automatic loadProgram();
		int          fd;
		int          ch;
		int          count;
		int          i;
		logic        badLine;
		logic [7:0]  tag;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  op;
		for (i = 0; i < 65536; i++)
			mem[i] = 8'h00;  // Unloaded bytes decode as NOP
		fd = $fopen("bench/programInput.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open bench/programInput.txt");
			otherErrors++;
			return;
		end
		while ($fscanf(fd, " %c", tag) == 1)
		begin
			badLine = 1'b0;
			case (tag)
				"P":
				begin
					if ($fscanf(fd, "%h %d", addr, count) != 2)
					begin
						badLine = 1'b1;
						count = 0;
					end
					for (i = 0; i < count; i++)
					begin
						if ($fscanf(fd, "%h", data) != 1)
							badLine = 1'b1;
						mem[addr] = data;
						addr = addr + 16'd1;
						progBytes++;
					end
				end
				"W":
				begin
					if ($fscanf(fd, "%h %h", addr, data) != 2)
						badLine = 1'b1;
					expAddr.push_back(addr);
					expData.push_back(data);
				end
				"A":
				begin
					// Expected byte is the logic op of the two given operands
					if ($fscanf(fd, "%h %h %h %h", addr, x, y, op) != 4)
						badLine = 1'b1;
					expAddr.push_back(addr);
					expData.push_back(logicResult(x, y, op[0]));
				end
				"#":
				begin
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end
				default: badLine = 1'b1;
			endcase
			if (badLine)
			begin
				$display("Malformed line in the program file, tag %c", tag);
				otherErrors++;
			end
		end
		$fclose(fd);
		expCount = expAddr.size();
	endtask

	// --------------------
	// Checks
	// --------------------
	task automatic checkIdleBus();
		assert (bus.we == 1'b0)
		else
		begin
			$display("MISMATCH bus.we: expected 0x0, got 0x%h", bus.we);
			mismatchCount++;
		end
		assert (bus.addr == 16'h0000)
		else
		begin
			$display("MISMATCH bus.addr: expected 0x0000, got 0x%h", bus.addr);
			mismatchCount++;
		end
	endtask

	task automatic checkWrite();
		if (writeIdx < expCount)
		begin
			assert (bus.addr == expAddr[writeIdx])
			else
			begin
				$display("MISMATCH bus.addr: expected 0x%h, got 0x%h (write %0d)",
					expAddr[writeIdx], bus.addr, writeIdx);
				mismatchCount++;
			end
			assert (bus.wData == expData[writeIdx])
			else
			begin
				$display("MISMATCH bus.wData: expected 0x%h, got 0x%h (write %0d)",
					expData[writeIdx], bus.wData, writeIdx);
				mismatchCount++;
			end
			writeIdx++;
		end
		else
		begin
			$display("Extra write of 0x%h to 0x%h after all expected writes", bus.wData, bus.addr);
			extraCount++;
		end
		mem[bus.addr] = bus.wData;
	endtask

	// Sampled half a cycle ahead of the edge that commits the write
	always @(negedge iClock)
	begin
		if (rstN && bus.we)
			checkWrite();
	end

	task automatic applyReset();
		rstN = 1'b0;
		@(posedge iClock);
		@(negedge iClock);
		checkIdleBus();
		@(posedge iClock);
		#1 rstN = 1'b1;
		@(negedge iClock);
		checkIdleBus();  // Still in afterReset here
	endtask

	task automatic finishRun(input logic timedOut);
		int missing;
		missing = expCount - writeIdx;
		if (missing > 0)
			$display("%0d expected writes never happened", missing);
		$display("Errors: mismatch %0d, extra %0d, missing %0d, other %0d",
			mismatchCount, extraCount, missing, otherErrors);
		if (!timedOut && mismatchCount == 0 && extraCount == 0 && missing == 0
			&& otherErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	// --------------------
	// Run control
	// --------------------
	initial
	begin
		rstN = 1'b0;
		loadProgram();
		timeLimit = progBytes * 8 * 4 + 400;  // 8 cycles of 4 units per byte
		loadDone = 1'b1;
		applyReset();
		wait (writeIdx == expCount);
		repeat (20)
			@(posedge iClock);
		finishRun(1'b0);
	end

	initial
	begin
		wait (loadDone);
		#(timeLimit);
		$display("Timeout: run did not finish within %0d time units", timeLimit);
		finishRun(1'b1);
	end

endmodule

// ==== bench/programInput.txt ====
# P addr count bytes... : program or data bytes from addr on
# W addr data : next expected write; A addr x y op : write of x AND y (op 0) or x XOR y (op 1)
# Immediate copied through E, D, B into A, stored at C0FE
P 0000 10 26 C0 2E FE 1E 5A 53 42 78 77
# AND C, INC HL, store; XOR D, INC HL with carry into H, store
P 000A 5 0E 3C A1 23 77
P 000F 5 16 F0 AA 23 77
# JR +2 jumps over two stores
P 0014 4 18 02 77 77
# Loop stores at FFFD..FFFF until INC HL wraps to zero
P 0018 6 26 FF 2E FD 3E 11
P 001E 6 77 23 28 02 18 FA
# LD A,(HL) from 0200 and store at 0201
P 0024 8 26 02 2E 00 7E 2E 01 77
# XOR A then JR Z taken over a store
P 002C 4 AF 28 01 77
# Nonzero AND then JR Z not taken, INC HL, store
P 0030 9 0E 0F 3E 35 A1 28 01 23 77
# Park in a tight loop
P 0039 2 18 FE
P 0200 1 C3
# Expected writes in order
W C0FE 5A
A C0FF 5A 3C 0
A C100 18 F0 1
W FFFD 11
W FFFE 11
W FFFF 11
W 0201 C3
A 0202 35 0F 0

// ==== src.f ====
rtl/regPkg.sv
rtl/uopPkg.sv
rtl/ucodeRom.sv
rtl/opcodeFlowLut.sv
rtl/flowSequencer.sv
rtl/regFile.sv
rtl/uopExecute.sv
rtl/cpuCore.sv
bench/clockGen.sv
bench/cpuBench.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuBench
RTL_TOP  = cpuCore
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
